// ==== tb.f ====
logic/cu_pagerank_pkg.sv
logic/vertex_job_queue.sv
logic/edge_index_reader.sv
logic/rank_fetch_control.sv
logic/read_command_path.sv
logic/read_data_demux.sv
logic/rank_sum_kernel.sv
logic/cu_vertex_pagerank.sv
tests/cu_vertex_pagerank_sva.sv
tests/tb_cu_vertex_pagerank.sv

// ==== tests/tb_cu_vertex_pagerank.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the PageRank vertex compute unit
// Random jobs, out-of-order memory model and a rank sum reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_cu_vertex_pagerank
	import cu_pagerank_pkg::*;
();

	localparam int NUM_JOBS   = 40;
	localparam int TIMEOUT    = 3000;
	localparam int STALL_HOLD = 100;

	logic          clock;
	logic          rstn;
	logic          vertex_job_valid;
	vertex_id_t    vertex_job_id;
	edge_index_t   vertex_job_edge_start;
	edge_index_t   vertex_job_degree;
	logic          vertex_job_request;
	logic          read_buffer_alfull;
	logic          read_command_bus_request;
	logic          read_command_bus_grant;
	logic          read_command_valid;
	array_struct_t read_command_array;
	address_t      read_command_address;
	logic          read_data_valid;
	array_struct_t read_data_array;
	rank_t         read_data_value;
	logic          write_valid;
	vertex_id_t    write_vertex;
	rank_t         write_sum;
	vertex_id_t    vertex_num_counter;
	edge_index_t   edge_num_counter;

	// Reference model state
	address_t      exp_edge_addr[$];
	vertex_id_t    exp_vertex[$];
	rank_t         exp_sum[$];
	vertex_id_t    returned_dests[$];

	// Memory model responses waiting for their return cycle
	array_struct_t pend_array[$];
	rank_t         pend_value[$];
	int            pend_due[$];

	int   mismatch_errors;
	int   other_errors;
	int   cycle;
	int   sent;
	int   writes_seen;
	int   total_degree;
	logic stall_grants;
	logic grant_d1;
	logic grant_d2;
	logic request_prev;
	logic request_fell;
	logic request_recovered;

	cu_vertex_pagerank #(
		.VERTEX_QUEUE_DEPTH(32),
		.READ_CMD_DEPTH(16),
		.EDGE_CREDITS(8)
	) dut_i (.*);

	always #10 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Memory contents and expected sums
	////////////////////////////////////////////////////////////////////////////

	function automatic vertex_id_t edge_dest_of(edge_index_t index);
		return vertex_id_t'(int'(index) * 37 + 11);
	endfunction

	function automatic rank_t rank_of(vertex_id_t vertex);
		return rank_t'(vertex) * 1000 + 5;
	endfunction

	function automatic rank_t expected_sum(edge_index_t start, edge_index_t degree);
		rank_t sum;
		sum = '0;
		for (int k = 0; k < int'(degree); k++) begin
			sum = sum + rank_of(edge_dest_of(start + edge_index_t'(k)));
		end
		return sum;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_vertex(string name, vertex_id_t expected, vertex_id_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			mismatch_errors++;
		end
	endtask

	task automatic compare_sum(string name, rank_t expected, rank_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
			mismatch_errors++;
		end
	endtask

	task automatic compare_address(string name, address_t expected, address_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
			mismatch_errors++;
		end
	endtask

	task automatic compare_count(string name, edge_index_t expected, edge_index_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			mismatch_errors++;
		end
	endtask

	task automatic report_error(string msg);
		$display("ERROR at %0t: %s", $time, msg);
		other_errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle monitor and responder
	////////////////////////////////////////////////////////////////////////////

	task automatic queue_response(array_struct_t array, rank_t value);
		pend_array.push_back(array);
		pend_value.push_back(value);
		pend_due.push_back(cycle + $urandom_range(1, 6));
	endtask

	task automatic check_handshakes();
		if (read_command_valid !== grant_d2) begin
			if (read_command_valid) begin
				report_error("read command without a grant two cycles earlier");
			end else begin
				report_error("grant not followed by a read command two cycles later");
			end
		end
		// Request set at the last edge saw the alfull driven one cycle before
		if (read_command_bus_request && !request_prev && read_buffer_alfull) begin
			report_error("bus request rose while read_buffer_alfull was high");
		end
	endtask

	task automatic sample_commands();
		int idx;
		if (!read_command_valid) begin
			return;
		end
		if (read_command_array == ARRAY_EDGE) begin
			if (exp_edge_addr.size() == 0) begin
				report_error("edge read issued with no edge left to read");
			end else begin
				compare_address("edge read address", exp_edge_addr.pop_front(),
					read_command_address);
			end
			queue_response(ARRAY_EDGE,
				rank_t'(edge_dest_of(edge_index_t'(read_command_address))));
		end else begin
			idx = -1;
			foreach (returned_dests[i]) begin
				if (idx < 0 && address_t'(returned_dests[i]) == read_command_address) begin
					idx = i;
				end
			end
			if (idx < 0) begin
				report_error("rank read for a destination the memory never returned");
			end else begin
				returned_dests.delete(idx);
			end
			queue_response(ARRAY_RANK, rank_of(vertex_id_t'(read_command_address)));
		end
	endtask

	task automatic sample_writes();
		if (!write_valid) begin
			return;
		end
		if (exp_vertex.size() == 0) begin
			report_error("result write with no job outstanding");
		end else begin
			compare_vertex($sformatf("write %0d vertex", writes_seen), exp_vertex.pop_front(),
				write_vertex);
			compare_sum($sformatf("write %0d sum", writes_seen), exp_sum.pop_front(),
				write_sum);
		end
		writes_seen++;
	endtask

	task automatic return_read_data();
		int idx;
		idx = -1;
		foreach (pend_due[i]) begin
			if (idx < 0 && pend_due[i] <= cycle) begin
				idx = i;
			end
		end
		read_data_valid = 1'b0;
		if (idx >= 0) begin
			read_data_valid = 1'b1;
			read_data_array = pend_array[idx];
			read_data_value = pend_value[idx];
			if (pend_array[idx] == ARRAY_EDGE) begin
				returned_dests.push_back(vertex_id_t'(pend_value[idx]));
			end
			pend_array.delete(idx);
			pend_value.delete(idx);
			pend_due.delete(idx);
		end
	endtask

	task automatic drive_bus_inputs();
		grant_d2 = grant_d1;
		read_command_bus_grant = read_command_bus_request && !stall_grants &&
			($urandom_range(0, 2) != 0);
		grant_d1 = read_command_bus_grant;
		request_prev = read_command_bus_request;
		read_buffer_alfull = ($urandom_range(0, 7) == 0);
	endtask

	// One falling edge, outputs sampled before any input changes
	task automatic tick();
		@(negedge clock);
		cycle++;
		vertex_job_valid = 1'b0;
		check_handshakes();
		sample_commands();
		sample_writes();
		return_read_data();
		drive_bus_inputs();
	endtask

	task automatic send_job();
		vertex_id_t  id;
		edge_index_t start;
		edge_index_t degree;
		id    = vertex_id_t'($urandom_range(0, 65535));
		start = edge_index_t'($urandom_range(0, 200000));
		if (sent % 9 == 4) begin
			degree = '0;
		end else begin
			degree = edge_index_t'($urandom_range(0, 12));
		end
		vertex_job_valid      = 1'b1;
		vertex_job_id         = id;
		vertex_job_edge_start = start;
		vertex_job_degree     = degree;
		for (int k = 0; k < int'(degree); k++) begin
			exp_edge_addr.push_back(address_t'(start + edge_index_t'(k)));
		end
		exp_vertex.push_back(id);
		exp_sum.push_back(expected_sum(start, degree));
		total_degree += int'(degree);
		sent++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int idle;
		int last;
		void'($urandom(68));
		clock                  = 1'b0;
		rstn                   = 1'b0;
		vertex_job_valid       = 1'b0;
		vertex_job_id          = '0;
		vertex_job_edge_start  = '0;
		vertex_job_degree      = '0;
		read_buffer_alfull     = 1'b0;
		read_command_bus_grant = 1'b0;
		read_data_valid        = 1'b0;
		read_data_array        = ARRAY_EDGE;
		read_data_value        = '0;
		mismatch_errors        = 0;
		other_errors           = 0;
		cycle                  = 0;
		sent                   = 0;
		writes_seen            = 0;
		total_degree           = 0;
		stall_grants           = 1'b1;
		grant_d1               = 1'b0;
		grant_d2               = 1'b0;
		request_prev           = 1'b0;
		request_fell           = 1'b0;
		request_recovered      = 1'b0;
		repeat (8) @(negedge clock);
		rstn = 1'b1;

		// Grants held off, jobs sent back to back until the queue is full
		idle = 0;
		while (!request_fell && sent < NUM_JOBS && idle < TIMEOUT) begin
			tick();
			if (vertex_job_request) begin
				send_job();
				idle = 0;
			end else if (sent > 0) begin
				request_fell = 1'b1;
			end else begin
				idle++;
			end
		end
		if (!request_fell) begin
			report_error("vertex_job_request did not fall while grants were stalled");
		end
		repeat (STALL_HOLD) tick();
		stall_grants = 1'b0;

		// Remaining jobs with random gaps
		idle = 0;
		while (sent < NUM_JOBS && idle < TIMEOUT) begin
			tick();
			if (vertex_job_request && request_fell) begin
				request_recovered = 1'b1;
			end
			if (vertex_job_request && $urandom_range(0, 2) != 0) begin
				send_job();
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (sent < NUM_JOBS) begin
			report_error("timed out waiting for vertex_job_request");
		end
		if (!request_recovered) begin
			report_error("vertex_job_request did not recover after the stall");
		end

		idle = 0;
		while (writes_seen < NUM_JOBS && idle < TIMEOUT) begin
			last = writes_seen;
			tick();
			if (writes_seen != last) begin
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (writes_seen < NUM_JOBS) begin
			report_error("timed out waiting for result writes");
		end
		// Drain so stray writes or reads still show up
		repeat (20) tick();

		if (exp_edge_addr.size() != 0) begin
			report_error("edge reads missing at the end of the run");
		end
		if (pend_due.size() != 0 || returned_dests.size() != 0) begin
			report_error("read traffic left over at the end of the run");
		end
		compare_vertex("vertex_num_counter", vertex_id_t'(NUM_JOBS), vertex_num_counter);
		compare_count("edge_num_counter", edge_index_t'(total_degree), edge_num_counter);

		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/cu_vertex_pagerank_sva.sv ====
////////////////////////////////////////////////////////////////////////////
// Handshake assertions for the PageRank vertex compute unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cu_vertex_pagerank_sva (
	input logic clock,
	input logic rstn,
	input logic read_buffer_alfull,
	input logic read_command_bus_request,
	input logic read_command_bus_grant,
	input logic read_command_valid,
	input logic write_valid
);

	// Command comes out exactly two cycles after its grant
	grant_to_command: assert property (@(posedge clock) disable iff (!rstn)
		read_command_bus_grant |-> ##2 read_command_valid)
		else $error("no read command two cycles after a grant");

	command_from_grant: assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |-> $past(read_command_bus_grant, 2))
		else $error("read command without a grant two cycles earlier");

	request_respects_alfull: assert property (@(posedge clock) disable iff (!rstn)
		$rose(read_command_bus_request) |-> !$past(read_buffer_alfull))
		else $error("bus request rose right after read_buffer_alfull");

	write_is_strobe: assert property (@(posedge clock) disable iff (!rstn)
		write_valid |=> !write_valid)
		else $error("write_valid held longer than one cycle");

endmodule

bind cu_vertex_pagerank cu_vertex_pagerank_sva sva_i (.*);

`default_nettype wire

// ==== logic/cu_vertex_pagerank.sv ====
////////////////////////////////////////////////////////////////////////////
// PageRank vertex compute unit
// Job queue, edge and rank fetch, shared read port and rank summation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cu_vertex_pagerank
	import cu_pagerank_pkg::*;
#(
	parameter int VERTEX_QUEUE_DEPTH = 32,
	parameter int READ_CMD_DEPTH     = 16,
	parameter int EDGE_CREDITS       = 8
) (
	input  logic          clock,
	input  logic          rstn,
	input  logic          vertex_job_valid,
	input  vertex_id_t    vertex_job_id,
	input  edge_index_t   vertex_job_edge_start,
	input  edge_index_t   vertex_job_degree,
	output logic          vertex_job_request,
	input  logic          read_buffer_alfull,
	output logic          read_command_bus_request,
	input  logic          read_command_bus_grant,
	output logic          read_command_valid,
	output array_struct_t read_command_array,
	output address_t      read_command_address,
	input  logic          read_data_valid,
	input  array_struct_t read_data_array,
	input  rank_t         read_data_value,
	output logic          write_valid,
	output vertex_id_t    write_vertex,
	output rank_t         write_sum,
	output vertex_id_t    vertex_num_counter,
	output edge_index_t   edge_num_counter
);

	// Current job
	logic        job_active;
	vertex_id_t  job_id;
	edge_index_t job_edge_start;
	edge_index_t job_degree;
	logic        vertex_done;

	// Command sources into the shared read port
	logic     edge_cmd_valid;
	address_t edge_cmd_address;
	logic     edge_cmd_ready;
	logic     rank_cmd_valid;
	address_t rank_cmd_address;
	logic     rank_cmd_ready;
	logic     credit_return;

	// Routed read data
	logic       edge_data_valid;
	vertex_id_t edge_dest;
	logic       rank_data_valid;
	rank_t      rank_value;

	vertex_job_queue #(.VERTEX_QUEUE_DEPTH(VERTEX_QUEUE_DEPTH)) vertex_job_queue_i (.*);

	edge_index_reader #(.EDGE_CREDITS(EDGE_CREDITS)) edge_index_reader_i (.*);

	rank_fetch_control #(.EDGE_CREDITS(EDGE_CREDITS)) rank_fetch_control_i (.*);

	read_command_path #(.READ_CMD_DEPTH(READ_CMD_DEPTH)) read_command_path_i (.*);

	read_data_demux read_data_demux_i (.*);

	rank_sum_kernel rank_sum_kernel_i (.*);

endmodule

`default_nettype wire

// ==== logic/rank_sum_kernel.sv ====
////////////////////////////////////////////////////////////////////////////
// Rank sum kernel
// Adds up returned ranks and writes the sum once all edges are in
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rank_sum_kernel
	import cu_pagerank_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_active,
	input  vertex_id_t  job_id,
	input  edge_index_t job_degree,
	input  logic        rank_data_valid,
	input  rank_t       rank_value,
	output logic        vertex_done,
	output logic        write_valid,
	output vertex_id_t  write_vertex,
	output rank_t       write_sum,
	output vertex_id_t  vertex_num_counter,
	output edge_index_t edge_num_counter
);

	logic        active_q;
	edge_index_t rank_count;
	rank_t       sum;
	logic        finish;

	// Done pulse blocks a second finish until the job drops
	assign finish = job_active && active_q && !vertex_done && (rank_count == job_degree);

	////////////////////////////////////////////////////////////////////////////
	// Accumulation and completion
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active_q    <= 1'b0;
			rank_count  <= '0;
			sum         <= '0;
			vertex_done <= 1'b0;
			write_valid <= 1'b0;
		end else begin
			active_q    <= job_active;
			vertex_done <= finish;
			write_valid <= finish;
			if (job_active && !active_q) begin
				rank_count <= '0;
				sum        <= '0;
			end else if (rank_data_valid) begin
				rank_count <= rank_count + 1'b1;
				sum        <= sum + rank_value;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (finish) begin
			write_vertex <= job_id;
			write_sum    <= sum;
		end
	end

	// Progress counters
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			if (finish) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
			if (rank_data_valid) begin
				edge_num_counter <= edge_num_counter + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/read_data_demux.sv ====
////////////////////////////////////////////////////////////////////////////
// Read data demux
// Steers returning data to the rank fetch or the summation by array tag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_data_demux
	import cu_pagerank_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          read_data_valid,
	input  array_struct_t read_data_array,
	input  rank_t         read_data_value,
	output logic          edge_data_valid,
	output vertex_id_t    edge_dest,
	output logic          rank_data_valid,
	output rank_t         rank_value
);

	rank_t data_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_valid <= 1'b0;
			rank_data_valid <= 1'b0;
		end else begin
			edge_data_valid <= read_data_valid && (read_data_array == ARRAY_EDGE);
			rank_data_valid <= read_data_valid && (read_data_array == ARRAY_RANK);
		end
	end

	always_ff @(posedge clock) begin
		data_q <= read_data_value;
	end

	// Edge words carry the destination id in the low bits
	assign edge_dest  = data_q[VERTEX_BITS-1:0];
	assign rank_value = data_q;

endmodule

`default_nettype wire

// ==== logic/read_command_path.sv ====
////////////////////////////////////////////////////////////////////////////
// Read command path
// Round-robin merge of edge and rank reads into a FIFO with bus handshake
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_command_path
	import cu_pagerank_pkg::*;
#(
	parameter int READ_CMD_DEPTH = 16
) (
	input  logic          clock,
	input  logic          rstn,
	input  logic          edge_cmd_valid,
	input  address_t      edge_cmd_address,
	input  logic          rank_cmd_valid,
	input  address_t      rank_cmd_address,
	input  logic          read_buffer_alfull,
	input  logic          read_command_bus_grant,
	output logic          edge_cmd_ready,
	output logic          rank_cmd_ready,
	output logic          read_command_bus_request,
	output logic          read_command_valid,
	output array_struct_t read_command_array,
	output address_t      read_command_address
);

	localparam int PW = (READ_CMD_DEPTH > 1) ? $clog2(READ_CMD_DEPTH) : 1;
	localparam int CW = $clog2(READ_CMD_DEPTH + 1);

	array_struct_t cmd_array_mem[READ_CMD_DEPTH];
	address_t      cmd_addr_mem [READ_CMD_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          push;
	logic          pop;
	logic          grant_q;
	array_struct_t last_array;
	array_struct_t push_array;
	address_t      push_address;

	////////////////////////////////////////////////////////////////////////////
	// Round-robin arbiter
	////////////////////////////////////////////////////////////////////////////

	assign full = (count == CW'(READ_CMD_DEPTH));

	// Contention goes to the source that did not win last
	assign edge_cmd_ready = edge_cmd_valid && !full &&
		(!rank_cmd_valid || last_array == ARRAY_RANK);
	assign rank_cmd_ready = rank_cmd_valid && !full &&
		(!edge_cmd_valid || last_array == ARRAY_EDGE);

	assign push         = edge_cmd_ready || rank_cmd_ready;
	assign push_array   = rank_cmd_ready ? ARRAY_RANK : ARRAY_EDGE;
	assign push_address = rank_cmd_ready ? rank_cmd_address : edge_cmd_address;
	assign pop          = grant_q && (count != '0);

	always_ff @(posedge clock) begin
		if (push) begin
			cmd_array_mem[wr_ptr] <= push_array;
			cmd_addr_mem[wr_ptr]  <= push_address;
		end
		if (pop) begin
			read_command_array   <= cmd_array_mem[rd_ptr];
			read_command_address <= cmd_addr_mem[rd_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr                   <= '0;
			rd_ptr                   <= '0;
			count                    <= '0;
			last_array               <= ARRAY_RANK;
			grant_q                  <= 1'b0;
			read_command_bus_request <= 1'b0;
			read_command_valid       <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr     <= (wr_ptr == PW'(READ_CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				last_array <= push_array;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(READ_CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count   <= count + CW'(push) - CW'(pop);
			grant_q <= read_command_bus_grant;
			// Grants already in flight will consume entries
			read_command_bus_request <= !read_buffer_alfull &&
				(int'(count) > int'(grant_q) + int'(read_command_bus_grant));
			read_command_valid <= pop;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rank_fetch_control.sv ====
////////////////////////////////////////////////////////////////////////////
// Rank fetch control
// Queues destination ids and issues rank-array reads for them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rank_fetch_control
	import cu_pagerank_pkg::*;
#(
	parameter int EDGE_CREDITS = 8
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       edge_data_valid,
	input  vertex_id_t edge_dest,
	input  logic       rank_cmd_ready,
	output logic       rank_cmd_valid,
	output address_t   rank_cmd_address,
	output logic       credit_return
);

	localparam int PW = (EDGE_CREDITS > 1) ? $clog2(EDGE_CREDITS) : 1;
	localparam int CW = $clog2(EDGE_CREDITS + 1);

	vertex_id_t    dest_mem[EDGE_CREDITS];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          pop;

	// Head of queue is the rank address
	assign rank_cmd_valid   = (count != '0);
	assign rank_cmd_address = address_t'(dest_mem[rd_ptr]);
	assign pop              = rank_cmd_valid && rank_cmd_ready;
	assign credit_return    = pop;

	always_ff @(posedge clock) begin
		if (edge_data_valid) begin
			dest_mem[wr_ptr] <= edge_dest;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (edge_data_valid) begin
				wr_ptr <= (wr_ptr == PW'(EDGE_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(EDGE_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(edge_data_valid) - CW'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== logic/edge_index_reader.sv ====
////////////////////////////////////////////////////////////////////////////
// Edge index reader
// Issues one edge-array read per edge of the current vertex, credit limited
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module edge_index_reader
	import cu_pagerank_pkg::*;
#(
	parameter int EDGE_CREDITS = 8
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_active,
	input  edge_index_t job_edge_start,
	input  edge_index_t job_degree,
	input  logic        edge_cmd_ready,
	input  logic        credit_return,
	output logic        edge_cmd_valid,
	output address_t    edge_cmd_address
);

	localparam int CRW = $clog2(EDGE_CREDITS + 1);

	logic           active_q;
	edge_index_t    issued;
	logic [CRW-1:0] credits;
	logic           take;

	// Hold off in the first active cycle while the edge count restarts
	assign edge_cmd_valid   = job_active && active_q && (issued < job_degree) &&
		(credits != '0);
	assign edge_cmd_address = address_t'(job_edge_start + issued);
	assign take             = edge_cmd_valid && edge_cmd_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active_q <= 1'b0;
			issued   <= '0;
			credits  <= CRW'(EDGE_CREDITS);
		end else begin
			active_q <= job_active;
			if (job_active && !active_q) begin
				issued <= '0;
			end else if (take) begin
				issued <= issued + 1'b1;
			end
			// One credit per edge until its destination leaves the rank queue
			credits <= credits - CRW'(take) + CRW'(credit_return);
		end
	end

endmodule

`default_nettype wire

// ==== logic/vertex_job_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// Vertex job queue
// Buffers incoming jobs and hands out one current job at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_queue
	import cu_pagerank_pkg::*;
#(
	parameter int VERTEX_QUEUE_DEPTH = 32
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        vertex_job_valid,
	input  vertex_id_t  vertex_job_id,
	input  edge_index_t vertex_job_edge_start,
	input  edge_index_t vertex_job_degree,
	input  logic        vertex_done,
	output logic        vertex_job_request,
	output logic        job_active,
	output vertex_id_t  job_id,
	output edge_index_t job_edge_start,
	output edge_index_t job_degree
);

	localparam int PW = (VERTEX_QUEUE_DEPTH > 1) ? $clog2(VERTEX_QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(VERTEX_QUEUE_DEPTH + 1);

	logic        in_valid;
	vertex_id_t  in_id;
	edge_index_t in_edge_start;
	edge_index_t in_degree;

	vertex_id_t  id_mem    [VERTEX_QUEUE_DEPTH];
	edge_index_t start_mem [VERTEX_QUEUE_DEPTH];
	edge_index_t degree_mem[VERTEX_QUEUE_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push;
	logic          pop;

	// Input register stage
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= vertex_job_valid;
		end
	end

	always_ff @(posedge clock) begin
		in_id         <= vertex_job_id;
		in_edge_start <= vertex_job_edge_start;
		in_degree     <= vertex_job_degree;
	end

	assign push = in_valid && (count != CW'(VERTEX_QUEUE_DEPTH));
	assign pop  = !job_active && (count != '0);

	always_ff @(posedge clock) begin
		if (push) begin
			id_mem[wr_ptr]     <= in_id;
			start_mem[wr_ptr]  <= in_edge_start;
			degree_mem[wr_ptr] <= in_degree;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr             <= '0;
			rd_ptr             <= '0;
			count              <= '0;
			vertex_job_request <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(VERTEX_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(VERTEX_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(push) - CW'(pop);
			// Jobs in the input stage and on the port still need a slot
			vertex_job_request <= (int'(count) + int'(in_valid) + int'(vertex_job_valid) + 2)
				<= VERTEX_QUEUE_DEPTH;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Current job register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_active <= 1'b0;
		end else if (vertex_done) begin
			job_active <= 1'b0;
		end else if (pop) begin
			job_active <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			job_id         <= id_mem[rd_ptr];
			job_edge_start <= start_mem[rd_ptr];
			job_degree     <= degree_mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/cu_pagerank_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// PageRank vertex compute unit shared definitions
// Field widths, id types and the array tag used on commands and data
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cu_pagerank_pkg;

	// Field widths
	parameter int VERTEX_BITS = 16;
	parameter int EDGE_BITS   = 24;
	parameter int DATA_BITS   = 32;
	parameter int ADDR_BITS   = 32;

	// Vertex id as held in the edge array
	typedef logic [VERTEX_BITS-1:0] vertex_id_t;

	// Edge index, also used for degrees and edge counts
	typedef logic [EDGE_BITS-1:0] edge_index_t;

	// Rank value or rank sum, unsigned and wrapping
	typedef logic [DATA_BITS-1:0] rank_t;

	// Read command address
	typedef logic [ADDR_BITS-1:0] address_t;

	// Target array of a read command or a returning data word
	typedef enum logic [0:0] {
		ARRAY_EDGE = 1'b0,
		ARRAY_RANK = 1'b1
	} array_struct_t;

endpackage

`default_nettype wire
